//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module branch_predictor_tb -f sources.f -o sim_bp

status=0
./obj_dir/sim_bp > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test FAILED" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

//--- sources.f
src/bp_pkg.sv
src/bhq_ctrl_if.sv
src/branch_history_queue.sv
src/pattern_table.sv
src/branch_resolve_unit.sv
src/branch_predictor_top.sv
testbench/branch_predictor_checker.sv
testbench/branch_predictor_tb.sv

//--- src/bhq_ctrl_if.sv
interface bhq_ctrl_if import bp_pkg::*; ();

	logic clear_en; // drop this row and all younger ones
	tag_t clear_index;
	logic shift_en; // retire this row and all older ones
	tag_t shift_index;
	logic fix_en; // corrected row goes into the cleared slot
	bhq_row_t fix_row;
	tag_t read_index; // tagged lookup, combinational
	bhq_row_t read_row;

	modport resolve (
		output clear_en, clear_index,
		output shift_en, shift_index,
		output fix_en, fix_row,
		output read_index,
		input read_row
	);

	modport queue (
		input clear_en, clear_index,
		input shift_en, shift_index,
		input read_index,
		output read_row
	);

endinterface

//--- src/bp_pkg.sv
package bp_pkg;

	// queue geometry, one slot always left empty
	localparam int BHQ_SIZE = 8;
	localparam int BHQ_TAG_BITS = $clog2(BHQ_SIZE); // 3

	// global history length
	localparam int HIST_BITS = 6;

	// pattern table geometry
	localparam int PHT_ENTRIES = 64;
	localparam int PHT_INDEX_BITS = $clog2(PHT_ENTRIES); // 6

	typedef logic [BHQ_TAG_BITS-1:0] tag_t; // queue slot number
	typedef logic [HIST_BITS-1:0] hist_t; // bit 0 is the youngest branch
	typedef logic [PHT_INDEX_BITS-1:0] pht_index_t;

	// two-bit saturating counter
	// upper bit set means predict taken
	typedef logic [1:0] counter_t;

	localparam counter_t COUNTER_RESET = 2'b01; // weakly not taken

	// one queue row, the speculative history right after a branch
	typedef struct packed {
		hist_t branch_history; // bit 0 is this branch's own direction
		pht_index_t pht_index; // counter index used to predict it
	} bhq_row_t;

endpackage

//--- src/branch_history_queue.sv
module branch_history_queue import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input logic write_en, // fetch row or fix row, picked at top
	input bhq_row_t write_row,
	bhq_ctrl_if.queue ctrl,
	output tag_t write_tag, // slot the row lands in
	output logic newest_valid,
	output bhq_row_t newest_row
);

	// oldest row sits at head, tail is the next free slot
	bhq_row_t rows [BHQ_SIZE];

	tag_t head;
	tag_t head_next;
	tag_t tail;
	tag_t tail_next;
	tag_t write_slot;
	tag_t newest_slot;

	// is idx inside the occupied span [h, t) of the ring
	function automatic logic in_range(tag_t idx, tag_t h, tag_t t);
		logic hit;
		if (h <= t) begin
			hit = (idx >= h) && (idx < t);
		end else begin
			// wrapped, occupied is everything outside [t, h)
			hit = !((idx < h) && (idx >= t));
		end
		return hit;
	endfunction

	always_comb begin
		head_next = head;
		tail_next = tail;

		// clear first, tail rolls back to the mispredicted slot
		if (ctrl.clear_en && in_range(ctrl.clear_index, head, tail)) begin
			tail_next = ctrl.clear_index;
		end

		// then shift, checked against the already cleared span
		if (ctrl.shift_en && in_range(ctrl.shift_index, head_next, tail_next)) begin
			head_next = ctrl.shift_index + 1'b1; // wraps mod BHQ_SIZE
		end

		// write goes to the tail left by clear and shift
		write_slot = tail_next;
		if (write_en) begin
			tail_next = tail_next + 1'b1;
			if (tail_next == head_next) begin
				head_next = head_next + 1'b1; // full, oldest row falls out
			end
		end
	end

	// row storage, no reset, validity lives in the pointers
	always_ff @(posedge clock) begin
		if (write_en) begin
			rows[write_slot] <= write_row;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else begin
			head <= head_next;
			tail <= tail_next;
		end
	end

	assign write_tag = write_slot; // equals clear_index on a fix
	assign newest_slot = tail - 1'b1; // row just below the tail
	assign newest_valid = (head != tail);
	assign newest_row = rows[newest_slot];

	// tagged read for the resolve unit
	assign ctrl.read_row = rows[ctrl.read_index];

endmodule

//--- src/branch_predictor_top.sv
module branch_predictor_top import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input pht_index_t fetch_pc, // low pc bits
	output logic pred_taken,
	output tag_t pred_tag,
	input logic resolve_valid,
	input tag_t resolve_tag,
	input logic resolve_taken,
	input logic retire_valid,
	input tag_t retire_tag,
	output logic mispredict,
	output hist_t history,
	output logic history_valid
);

	bhq_ctrl_if ctrl ();

	logic write_en;
	bhq_row_t write_row;
	bhq_row_t fetch_row;
	tag_t write_tag;
	logic newest_valid;
	bhq_row_t newest_row;
	hist_t cur_history;
	pht_index_t pht_index;
	counter_t read_counter;
	logic update_en;
	pht_index_t update_index;
	logic update_taken;

	// speculative history, zero when the queue is empty
	assign cur_history = newest_valid ? newest_row.branch_history : '0;

	// gshare
	assign pht_index = fetch_pc ^ cur_history;
	assign pred_taken = read_counter[1];

	assign fetch_row.branch_history = {cur_history[HIST_BITS-2:0], pred_taken};
	assign fetch_row.pht_index = pht_index;

	// fix wins, a fetch alongside a mispredict is wrong path
	assign write_en = ctrl.fix_en || fetch_valid;
	assign write_row = ctrl.fix_en ? ctrl.fix_row : fetch_row;

	assign pred_tag = write_tag;
	assign history = cur_history;
	assign history_valid = newest_valid;

	branch_history_queue u_queue (
		.clock(clock),
		.reset(reset),
		.write_en(write_en),
		.write_row(write_row),
		.ctrl(ctrl.queue),
		.write_tag(write_tag),
		.newest_valid(newest_valid),
		.newest_row(newest_row)
	);

	pattern_table u_pht (
		.clock(clock),
		.reset(reset),
		.read_index(pht_index),
		.read_counter(read_counter),
		.update_en(update_en),
		.update_index(update_index),
		.update_taken(update_taken)
	);

	branch_resolve_unit u_resolve (
		.resolve_valid(resolve_valid),
		.resolve_tag(resolve_tag),
		.resolve_taken(resolve_taken),
		.retire_valid(retire_valid),
		.retire_tag(retire_tag),
		.ctrl(ctrl.resolve),
		.update_en(update_en),
		.update_index(update_index),
		.update_taken(update_taken),
		.mispredict(mispredict)
	);

endmodule

//--- src/branch_resolve_unit.sv
module branch_resolve_unit import bp_pkg::*; (
	input logic resolve_valid,
	input tag_t resolve_tag,
	input logic resolve_taken, // real outcome from execute
	input logic retire_valid,
	input tag_t retire_tag,
	bhq_ctrl_if.resolve ctrl,
	output logic update_en,
	output pht_index_t update_index,
	output logic update_taken,
	output logic mispredict
);

	logic predicted_taken;
	hist_t fixed_history;

	// look up the resolving branch by its tag
	assign ctrl.read_index = resolve_tag;
	assign predicted_taken = ctrl.read_row.branch_history[0]; // own direction bit

	assign mispredict = resolve_valid && (resolve_taken != predicted_taken);

	// same history, own bit flipped to the real outcome
	assign fixed_history = {ctrl.read_row.branch_history[HIST_BITS-1:1], resolve_taken};

	// recovery drops the row and everything younger,
	// then rewrites the slot with the corrected row
	assign ctrl.clear_en = mispredict;
	assign ctrl.clear_index = resolve_tag;
	assign ctrl.fix_en = mispredict;
	assign ctrl.fix_row.branch_history = fixed_history;
	assign ctrl.fix_row.pht_index = ctrl.read_row.pht_index; // keep original index

	// retire frees this row and all older ones
	assign ctrl.shift_en = retire_valid;
	assign ctrl.shift_index = retire_tag;

	// every resolve trains the counter it predicted with
	assign update_en = resolve_valid;
	assign update_index = ctrl.read_row.pht_index;
	assign update_taken = resolve_taken;

endmodule

//--- src/pattern_table.sv
module pattern_table import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input pht_index_t read_index, // predict side
	output counter_t read_counter,
	input logic update_en, // train side
	input pht_index_t update_index,
	input logic update_taken
);

	counter_t counters [PHT_ENTRIES];

	counter_t update_old;
	counter_t update_new;

	// combinational lookup for the fetch
	assign read_counter = counters[read_index];

	// one step toward the outcome, pinned at 0 and 3
	always_comb begin
		update_old = counters[update_index];
		update_new = update_old;
		if (update_taken) begin
			if (update_old != 2'b11) begin
				update_new = update_old + 1'b1;
			end
		end else begin
			if (update_old != 2'b00) begin
				update_new = update_old - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < PHT_ENTRIES; i++) begin
				counters[i] <= COUNTER_RESET; // all weakly not taken
			end
		end else if (update_en) begin
			counters[update_index] <= update_new;
		end
	end

endmodule

//--- testbench/bp_stim.txt
// fetch_valid fetch_pc resolve_valid resolve_tag resolve_taken retire_valid retire_tag
// exp: pred_taken pred_tag mispredict history history_valid, mask (1 pred_taken 2 pred_tag)
1 05 0 0 0 0 0  0 0 0 00 0 00
1 0a 0 0 0 0 0  0 1 0 00 1 00
1 13 0 0 0 0 0  0 2 0 00 1 00
0 00 1 2 1 0 0  0 0 1 00 1 03
0 00 1 2 1 0 0  0 0 0 01 1 03
1 12 0 0 0 0 0  1 3 0 01 1 00
1 00 0 0 0 0 0  0 4 0 03 1 00
1 3f 1 3 0 0 0  0 0 1 06 1 03
1 01 0 0 0 0 0  0 4 0 02 1 00
0 00 1 1 1 0 0  0 0 1 04 1 03
1 0b 0 0 0 0 0  1 2 0 01 1 00
0 00 0 0 0 1 0  0 0 0 03 1 03
0 00 0 0 0 1 2  0 0 0 03 1 03
0 00 0 0 0 0 0  0 0 0 00 0 03
1 20 0 0 0 0 0  0 3 0 00 0 00
1 21 0 0 0 0 0  0 4 0 00 1 00
1 0a 0 0 0 0 0  1 5 0 00 1 00
1 22 0 0 0 0 0  0 6 0 01 1 00
1 24 0 0 0 0 0  0 7 0 02 1 00
1 25 0 0 0 0 0  0 0 0 04 1 00
1 26 0 0 0 0 0  0 1 0 08 1 00
1 27 0 0 0 0 0  0 2 0 10 1 00
1 28 0 0 0 0 0  0 3 0 20 1 00
0 00 0 0 0 1 4  0 0 0 00 1 03
0 00 1 5 1 0 0  0 0 0 00 1 03
0 00 0 0 0 1 3  0 0 0 00 1 03
1 0a 0 0 0 0 0  1 4 0 00 0 00
0 00 1 4 0 0 0  0 0 1 01 1 03
0 00 0 0 0 0 0  0 0 0 00 1 03

//--- testbench/branch_predictor_checker.sv
module branch_predictor_checker import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input logic write_en,
	input tag_t write_tag,
	input logic clear_en,
	input tag_t clear_index,
	input logic newest_valid,
	input tag_t head,
	input tag_t tail
);

	timeunit 1ns;
	timeprecision 1ps;

	// queue comes out of reset empty
	assert property (@(posedge clock) reset |=> !newest_valid)
		else $error("queue holds a row right after reset");

	// fix row lands in the slot that was cleared
	assert property (@(posedge clock) disable iff (reset)
		(write_en && clear_en) |-> (write_tag == clear_index))
		else $error("fix write tag %0d differs from clear index %0d", write_tag, clear_index);

	// one slot always stays free so a write never brings the tail onto the head
	assert property (@(posedge clock) disable iff (reset)
		write_en |=> (head != tail))
		else $error("write left the queue looking empty, more than %0d rows", BHQ_SIZE - 1);

endmodule

bind branch_history_queue branch_predictor_checker u_checker (
	.clock(clock),
	.reset(reset),
	.write_en(write_en),
	.write_tag(write_tag),
	.clear_en(ctrl.clear_en),
	.clear_index(ctrl.clear_index),
	.newest_valid(newest_valid),
	.head(head),
	.tail(tail)
);

//--- testbench/branch_predictor_tb.sv
module branch_predictor_tb import bp_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 2;
	localparam int NUM_FIELDS = 13; // hex tokens per stim line
	localparam int MAX_LINES = 64;
	localparam int TIMEOUT_MARGIN = 20;

	logic clock;
	logic reset;
	logic fetch_valid;
	pht_index_t fetch_pc;
	logic pred_taken;
	tag_t pred_tag;
	logic resolve_valid;
	tag_t resolve_tag;
	logic resolve_taken;
	logic retire_valid;
	tag_t retire_tag;
	logic mispredict;
	hist_t history;
	logic history_valid;

	logic [7:0] stim_mem [NUM_FIELDS*MAX_LINES]; // flat, line after line
	int num_lines;
	int timeout_limit;
	int cycle_count = 0;
	int line;

	branch_predictor_top DUT (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.pred_taken(pred_taken),
		.pred_tag(pred_tag),
		.resolve_valid(resolve_valid),
		.resolve_tag(resolve_tag),
		.resolve_taken(resolve_taken),
		.retire_valid(retire_valid),
		.retire_tag(retire_tag),
		.mispredict(mispredict),
		.history(history),
		.history_valid(history_valid)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// hard stop if the stim loop stalls
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout, run did not finish within %0d cycles", timeout_limit);
			$display("Test FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input int line_no,
			input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			$display("error: %s at stim line %0d, expected %0h, actual %0h",
				name, line_no, expected, actual);
			$display("Test FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic load_stim();
		int i;
		for (i = 0; i < NUM_FIELDS * MAX_LINES; i++) begin
			stim_mem[i] = 8'hff; // ff in column 0 marks the end
		end
		$readmemh("testbench/bp_stim.txt", stim_mem);
		num_lines = 0;
		while (num_lines < MAX_LINES && stim_mem[num_lines * NUM_FIELDS] != 8'hff) begin
			num_lines++;
		end
	endtask

	// inputs, columns 0 to 6
	task automatic drive_line(input int line_no);
		int base;
		base = line_no * NUM_FIELDS;
		fetch_valid <= stim_mem[base][0];
		fetch_pc <= stim_mem[base + 1][PHT_INDEX_BITS-1:0];
		resolve_valid <= stim_mem[base + 2][0];
		resolve_tag <= stim_mem[base + 3][BHQ_TAG_BITS-1:0];
		resolve_taken <= stim_mem[base + 4][0];
		retire_valid <= stim_mem[base + 5][0];
		retire_tag <= stim_mem[base + 6][BHQ_TAG_BITS-1:0];
	endtask

	// expected values in columns 7 to 11, mask in 12
	task automatic check_line(input int line_no);
		int base;
		logic [7:0] mask;
		base = line_no * NUM_FIELDS;
		mask = stim_mem[base + 12]; // set bit, column not checked
		if (!mask[0])
			check_value("pred_taken", line_no, stim_mem[base + 7], 8'(pred_taken));
		if (!mask[1])
			check_value("pred_tag", line_no, stim_mem[base + 8], 8'(pred_tag));
		if (!mask[2])
			check_value("mispredict", line_no, stim_mem[base + 9], 8'(mispredict));
		if (!mask[3])
			check_value("history", line_no, stim_mem[base + 10], 8'(history));
		if (!mask[4])
			check_value("history_valid", line_no, stim_mem[base + 11], 8'(history_valid));
	endtask

	initial begin
		reset <= 1'b1;
		fetch_valid <= 1'b0;
		fetch_pc <= '0;
		resolve_valid <= 1'b0;
		resolve_tag <= '0;
		resolve_taken <= 1'b0;
		retire_valid <= 1'b0;
		retire_tag <= '0;
		load_stim();
		timeout_limit = num_lines + TIMEOUT_MARGIN;
		if (num_lines == 0) begin
			$display("stim file is missing or holds no lines");
			$display("Test FAILED");
			$fatal(1, "no stimulus");
		end
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (line = 0; line < num_lines; line++) begin
			drive_line(line);
			#(CLK_PERIOD - 1); // just before the next edge
			check_line(line);
			@(posedge clock);
		end
		$display("Test OK");
		$finish;
	end

endmodule
